// File: bench/ntt_stim.txt
// one test per line as hex kaaaa, k is the kind and aaaa its argument
// kinds 0 zero, 1 impulse at index, 2 constant value, 3 ramp, 4 random with count near q-1
00000
10000
100a7
100ff
20001
20d00
30000
40000
40040
40100

// File: sim.f
common/ntt_pkg.sv
logic/twiddle_rom.sv
ntt_core/ntt_ctrl.sv
ntt_core/coeff_bank.sv
ntt_core/bfu_array.sv
ntt_core/ntt_top.sv
bench/ntt_asserts.sv
bench/ntt_checker.sv
bench/ntt_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the ntt testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module ntt_tb \
    -Mdir obj_dir -o ntt_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "verilator build failed, see build.log"
    exit 1
fi

./obj_dir/ntt_sim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status, see sim.log"
    exit 1
fi

if grep -qx "Done: no errors" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL, see sim.log"
exit 1

// File: bench/ntt_tb.sv
`timescale 1ns/1ps

module ntt_tb import ntt_pkg::*; ();

    localparam int NUM_BFU     = 8;
    localparam int CLK_PERIOD  = 8;
    localparam int MAX_TESTS   = 32;
    // last input strobe to first output word
    localparam int LATENCY     = LAYERS * (128 / NUM_BFU + 1) + 1;
    localparam int JUNK_CYCLES = LATENCY + N / 2;

    localparam logic [3:0] K_ZERO    = 4'h0;
    localparam logic [3:0] K_IMPULSE = 4'h1;
    localparam logic [3:0] K_CONST   = 4'h2;
    localparam logic [3:0] K_RAMP    = 4'h3;
    localparam logic [3:0] K_RANDOM  = 4'h4;
    localparam logic [3:0] K_END     = 4'hf;

    logic        i_clk;
    logic        i_rst;
    logic        i_in_valid;
    coef_t       i_data;
    logic        o_valid;
    coef_t       o_data;
    logic        ref_push;
    coef_t       test_vec [N];
    logic [19:0] stim_mem [MAX_TESTS];
    int          num_tests;
    int          tests_done;
    int          word_errors;
    int          count_errors;
    int          assert_errors;
    int          setup_errors;
    int          total_errors;
    int unsigned rng_state = 74;

    ntt_top #(.NUM_BFU(NUM_BFU)) i_dut (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_in_valid (i_in_valid),
        .i_data     (i_data),
        .o_valid    (o_valid),
        .o_data     (o_data)
    );

    ntt_checker u_checker (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_valid        (o_valid),
        .i_data         (o_data),
        .i_ref_push     (ref_push),
        .i_ref          (test_vec),
        .o_tests_done   (tests_done),
        .o_word_errors  (word_errors),
        .o_count_errors (count_errors)
    );

    bind ntt_ctrl ntt_asserts u_asserts (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_state (state),
        .i_cmd   (o_cmd),
        .i_valid (o_valid)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    function automatic int unsigned lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state >> 8;
    endfunction

    task automatic build_vector(input logic [3:0] kind, input logic [15:0] arg);
        for (int i = 0; i < N; i++) begin
            case (kind)
                K_ZERO:    test_vec[i] = '0;
                K_IMPULSE: test_vec[i] = (i == int'(arg)) ? coef_t'(1) : coef_t'(0);
                K_CONST:   test_vec[i] = coef_t'(int'(arg) % Q);
                K_RAMP:    test_vec[i] = coef_t'(i * 13);
                K_RANDOM: begin
                    // first arg inputs sit just below q
                    if (i < int'(arg)) begin
                        test_vec[i] = coef_t'(Q - 1 - int'(lcg_next() % 8));
                    end else begin
                        test_vec[i] = coef_t'(lcg_next() % Q);
                    end
                end
                default:   test_vec[i] = '0;
            endcase
        end
    endtask

    task automatic apply_test(input logic [3:0] kind, input logic [15:0] arg,
                              input int done_target);
        int i;
        i = 0;
        build_vector(kind, arg);
        while (i < N) begin
            @(posedge i_clk);
            if (kind == K_RANDOM && (lcg_next() % 4) == 0) begin
                i_in_valid <= 1'b0;
            end else begin
                i_in_valid <= 1'b1;
                i_data     <= test_vec[i];
                i++;
            end
        end
        @(posedge i_clk);
        ref_push   <= 1'b1;
        i_in_valid <= 1'b0;
        // stray strobes through compute and part of unload
        for (int c = 0; c < JUNK_CYCLES; c++) begin
            @(posedge i_clk);
            ref_push   <= 1'b0;
            i_in_valid <= c[0];
            i_data     <= coef_t'(lcg_next() % Q);
        end
        @(posedge i_clk);
        i_in_valid <= 1'b0;
        wait (tests_done == done_target);
    endtask

    initial begin
        int limit_ns;
        wait (num_tests > 0);
        limit_ns = num_tests * (3 * N + LATENCY + 64) * CLK_PERIOD;
        #(limit_ns);
        $display("run timed out with %0d of %0d tests finished", tests_done, num_tests);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        i_rst      <= 1'b1;
        i_in_valid <= 1'b0;
        i_data     <= '0;
        ref_push   <= 1'b0;
        setup_errors = 0;
        for (int t = 0; t < MAX_TESTS; t++) begin
            stim_mem[t] = '1;
        end
        $readmemh("bench/ntt_stim.txt", stim_mem);
        num_tests = 0;
        while (num_tests < MAX_TESTS && stim_mem[num_tests][19:16] != K_END) begin
            num_tests++;
        end
        if (num_tests == 0) begin
            $display("stimulus file holds no tests");
            setup_errors = 1;
        end
        repeat (2) @(posedge i_clk);
        i_rst <= 1'b0;
        for (int t = 0; t < num_tests; t++) begin
            apply_test(stim_mem[t][19:16], stim_mem[t][15:0], t + 1);
        end
        repeat (4) @(posedge i_clk);
        assert_errors = int'(i_dut.u_ctrl.u_asserts.fail_count);
        total_errors  = word_errors + count_errors + assert_errors + setup_errors;
        $display("tests %0d, word errors %0d, count errors %0d, assertion errors %0d",
                 tests_done, word_errors, count_errors, assert_errors);
        if (total_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: bench/ntt_checker.sv
`timescale 1ns/1ps

module ntt_checker import ntt_pkg::*; (
    input  logic  i_clk,
    input  logic  i_rst,
    input  logic  i_valid,
    input  coef_t i_data,
    input  logic  i_ref_push,
    input  coef_t i_ref [N],
    output int    o_tests_done,
    output int    o_word_errors,
    output int    o_count_errors
);

    coef_t exp_q [$];
    coef_t exp_word;
    int    run_len;

    // in-place cooley-tukey over the bit-reversed zetas
    task automatic push_expected();
        int a [N];
        int half;
        int lo;
        int hi;
        int z;
        int t;
        for (int i = 0; i < N; i++) begin
            a[i] = int'(i_ref[i]);
        end
        for (int l = 0; l < LAYERS; l++) begin
            half = 128 >> l;
            for (int k = 0; k < 128; k++) begin
                lo = int'(pair_lo_index(3'(l), 7'(k)));
                hi = lo + half;
                z  = int'(zeta_of(7'((1 << l) + (k >> (7 - l)))));
                t  = (z * a[hi]) % Q;
                a[hi] = (a[lo] - t + Q) % Q;
                a[lo] = (a[lo] + t) % Q;
            end
        end
        for (int i = 0; i < N; i++) begin
            exp_q.push_back(coef_t'(a[i]));
        end
    endtask

    always @(posedge i_clk) begin
        if (i_rst) begin
            run_len = 0;
            exp_q.delete();
            o_tests_done   <= 0;
            o_word_errors  <= 0;
            o_count_errors <= 0;
        end else begin
            if (i_ref_push) begin
                push_expected();
            end
            if (i_valid) begin
                // nothing queued means output while loading or after reset
                if (exp_q.size() == 0) begin
                    $display("output word %0d arrived with no loaded test", run_len);
                    o_count_errors <= o_count_errors + 1;
                end else begin
                    exp_word = exp_q.pop_front();
                    if (i_data !== exp_word) begin
                        $display("Error o_data[%0d] expected 0x%03h got 0x%03h",
                                 run_len, exp_word, i_data);
                        o_word_errors <= o_word_errors + 1;
                    end
                end
                run_len++;
            end else if (run_len != 0) begin
                if (run_len != N) begin
                    $display("test %0d gave %0d output words instead of %0d",
                             o_tests_done + 1, run_len, N);
                    o_count_errors <= o_count_errors + 1;
                end
                exp_q.delete();
                o_tests_done <= o_tests_done + 1;
                run_len = 0;
            end
        end
    end

endmodule

// File: bench/ntt_asserts.sv
`timescale 1ns/1ps

module ntt_asserts import ntt_pkg::*; (
    input logic        i_clk,
    input logic        i_rst,
    input ctrl_state_t i_state,
    input bfu_cmd_t    i_cmd,
    input logic        i_valid
);

    int unsigned fail_count = 0;

    // unload begins only after the drain of the last layer
    unload_after_last_drain: assert property (
        @(posedge i_clk) disable iff (i_rst)
            $rose(i_valid) |->
                $past((i_state == ST_DRAIN) && (i_cmd.layer == 3'(LAYERS - 1)))
    ) else begin
        $error("o_valid rose without a drain of the last layer");
        fail_count++;
    end

    // issue stops only into a drain cycle
    issue_ends_in_drain: assert property (
        @(posedge i_clk) disable iff (i_rst)
            $fell(i_cmd.valid) |-> (i_state == ST_DRAIN)
    ) else begin
        $error("group issue stopped without entering ST_DRAIN");
        fail_count++;
    end

    layer_in_range: assert property (
        @(posedge i_clk) disable iff (i_rst) i_cmd.layer <= 3'(LAYERS - 1)
    ) else begin
        $error("layer counter beyond the last layer");
        fail_count++;
    end

endmodule

// File: ntt_core/ntt_top.sv
`timescale 1ns/1ps

module ntt_top import ntt_pkg::*; #(
    parameter int NUM_BFU = 8
) (
    input  logic  i_clk,
    input  logic  i_rst,
    input  logic  i_in_valid,
    input  coef_t i_data,
    output logic  o_valid,
    output coef_t o_data
);

    logic                 load_en;
    logic [IDX_W-1:0]     addr;
    bfu_cmd_t             cmd;
    bfu_cmd_t             wb_cmd;
    coef_t [NUM_BFU-1:0]  rd_lo;
    coef_t [NUM_BFU-1:0]  rd_hi;
    coef_t [NUM_BFU-1:0]  zeta;
    coef_t [NUM_BFU-1:0]  wb_lo;
    coef_t [NUM_BFU-1:0]  wb_hi;

    // lane count must divide the 128 butterflies of a layer
    if (NUM_BFU < 1 || NUM_BFU > 64 || (NUM_BFU & (NUM_BFU - 1)) != 0) begin : g_bad_num_bfu
        $error("NUM_BFU must be a power of two from 1 to 64");
    end

    ntt_ctrl #(.NUM_BFU(NUM_BFU)) u_ctrl (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_in_valid (i_in_valid),
        .o_load_en  (load_en),
        .o_addr     (addr),
        .o_cmd      (cmd),
        .o_valid    (o_valid)
    );

    coeff_bank #(.NUM_BFU(NUM_BFU)) u_bank (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_load_en  (load_en),
        .i_addr     (addr),
        .i_data     (i_data),
        .i_cmd      (cmd),
        .o_lo       (rd_lo),
        .o_hi       (rd_hi),
        .i_wb_cmd   (wb_cmd),
        .i_wb_lo    (wb_lo),
        .i_wb_hi    (wb_hi),
        .o_data     (o_data)
    );

    twiddle_rom #(.NUM_BFU(NUM_BFU)) u_rom (
        .i_cmd      (cmd),
        .o_zeta     (zeta)
    );

    bfu_array #(.NUM_BFU(NUM_BFU)) u_bfu (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_cmd      (cmd),
        .i_lo       (rd_lo),
        .i_hi       (rd_hi),
        .i_zeta     (zeta),
        .o_wb_cmd   (wb_cmd),
        .o_wb_lo    (wb_lo),
        .o_wb_hi    (wb_hi)
    );

endmodule

// File: ntt_core/bfu_array.sv
`timescale 1ns/1ps

module bfu_array import ntt_pkg::*; #(
    parameter int NUM_BFU = 8
) (
    input  logic                i_clk,
    input  logic                i_rst,
    input  bfu_cmd_t            i_cmd,
    input  coef_t [NUM_BFU-1:0] i_lo,
    input  coef_t [NUM_BFU-1:0] i_hi,
    input  coef_t [NUM_BFU-1:0] i_zeta,
    output bfu_cmd_t            o_wb_cmd,
    output coef_t [NUM_BFU-1:0] o_wb_lo,
    output coef_t [NUM_BFU-1:0] o_wb_hi
);

    // barrett constant floor(2^24 / q), product stays below 2^24
    localparam int         BARRETT_K = 24;
    localparam logic [12:0] BARRETT_M = 13'((1 << BARRETT_K) / Q);

    coef_t nxt_lo [NUM_BFU];
    coef_t nxt_hi [NUM_BFU];

    for (genvar g = 0; g < NUM_BFU; g++) begin : g_lane
        logic [23:0] prod;
        logic [36:0] prod_m;
        logic [12:0] q_est;
        logic [23:0] rem;
        coef_t       t;
        logic [12:0] sum;

        assign prod   = 24'(i_zeta[g]) * 24'(i_hi[g]);
        assign prod_m = 37'(prod) * 37'(BARRETT_M);
        assign q_est  = 13'(prod_m >> BARRETT_K);

        // estimate is at most one short, so rem < 2q
        assign rem = prod - 24'(q_est) * 24'(Q);
        assign t   = coef_t'((rem >= 24'(Q)) ? rem - 24'(Q) : rem);

        assign sum = {1'b0, i_lo[g]} + {1'b0, t};
        assign nxt_lo[g] = coef_t'((sum >= 13'(Q)) ? sum - 13'(Q) : sum);
        assign nxt_hi[g] = (i_lo[g] >= t) ? i_lo[g] - t
                                          : i_lo[g] + (coef_t'(Q) - t);
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_wb_cmd <= '0;
        end else begin
            o_wb_cmd <= i_cmd;
        end
    end

    always_ff @(posedge i_clk) begin
        for (int i = 0; i < NUM_BFU; i++) begin
            o_wb_lo[i] <= nxt_lo[i];
            o_wb_hi[i] <= nxt_hi[i];
        end
    end

endmodule

// File: ntt_core/coeff_bank.sv
`timescale 1ns/1ps

module coeff_bank import ntt_pkg::*; #(
    parameter int NUM_BFU = 8
) (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_load_en,
    input  logic [IDX_W-1:0]    i_addr,
    input  coef_t               i_data,
    input  bfu_cmd_t            i_cmd,
    output coef_t [NUM_BFU-1:0] o_lo,
    output coef_t [NUM_BFU-1:0] o_hi,
    input  bfu_cmd_t            i_wb_cmd,
    input  coef_t [NUM_BFU-1:0] i_wb_lo,
    input  coef_t [NUM_BFU-1:0] i_wb_hi,
    output coef_t               o_data
);

    coef_t            mem [N];
    logic [IDX_W-1:0] rd_lo_idx [NUM_BFU];
    logic [IDX_W-1:0] rd_hi_idx [NUM_BFU];
    logic [IDX_W-1:0] wb_lo_idx [NUM_BFU];
    logic [IDX_W-1:0] wb_hi_idx [NUM_BFU];
    logic [IDX_W-1:0] rd_half;
    logic [IDX_W-1:0] wb_half;

    // pair distance for the issued and the returning layer
    assign rd_half = IDX_W'(128) >> i_cmd.layer;
    assign wb_half = IDX_W'(128) >> i_wb_cmd.layer;

    always_comb begin
        for (int i = 0; i < NUM_BFU; i++) begin
            rd_lo_idx[i] = pair_lo_index(i_cmd.layer, i_cmd.group_base + 7'(i));
            rd_hi_idx[i] = rd_lo_idx[i] + rd_half;
            wb_lo_idx[i] = pair_lo_index(i_wb_cmd.layer, i_wb_cmd.group_base + 7'(i));
            wb_hi_idx[i] = wb_lo_idx[i] + wb_half;
            o_lo[i]      = mem[rd_lo_idx[i]];
            o_hi[i]      = mem[rd_hi_idx[i]];
        end
    end

    // unload reads straight from the array
    assign o_data = mem[i_addr];

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            for (int i = 0; i < N; i++) begin
                mem[i] <= '0;
            end
        end else begin
            if (i_load_en) begin
                mem[i_addr] <= i_data;
            end
            if (i_wb_cmd.valid) begin
                for (int i = 0; i < NUM_BFU; i++) begin
                    mem[wb_lo_idx[i]] <= i_wb_lo[i];
                    mem[wb_hi_idx[i]] <= i_wb_hi[i];
                end
            end
        end
    end

endmodule

// File: ntt_core/ntt_ctrl.sv
`timescale 1ns/1ps

module ntt_ctrl import ntt_pkg::*; #(
    parameter int NUM_BFU = 8
) (
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic             i_in_valid,
    output logic             o_load_en,
    output logic [IDX_W-1:0] o_addr,
    output bfu_cmd_t         o_cmd,
    output logic             o_valid
);

    localparam logic [6:0]       GROUP_STEP = 7'(NUM_BFU);
    localparam logic [6:0]       LAST_BASE  = 7'(128 - NUM_BFU);
    localparam logic [2:0]       LAST_LAYER = 3'(LAYERS - 1);
    localparam logic [IDX_W-1:0] LAST_IDX   = IDX_W'(N - 1);

    ctrl_state_t      state;
    logic [IDX_W-1:0] idx;
    logic [2:0]       layer;
    logic [6:0]       group_base;

    // strobes outside load are dropped here
    assign o_load_en = (state == ST_LOAD) && i_in_valid;
    assign o_valid   = (state == ST_UNLOAD);

    // one counter serves both load and unload
    assign o_addr = idx;

    always_comb begin
        o_cmd.valid      = (state == ST_COMPUTE);
        o_cmd.layer      = layer;
        o_cmd.group_base = group_base;
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state      <= ST_LOAD;
            idx        <= '0;
            layer      <= '0;
            group_base <= '0;
        end else begin
            case (state)
                ST_LOAD: begin
                    if (i_in_valid) begin
                        idx <= idx + 1'b1;
                        if (idx == LAST_IDX) begin
                            state <= ST_COMPUTE;
                        end
                    end
                end

                ST_COMPUTE: begin
                    // wraps back to zero after the last group
                    group_base <= group_base + GROUP_STEP;
                    if (group_base == LAST_BASE) begin
                        state <= ST_DRAIN;
                    end
                end

                // lets the last write-back of the layer land
                ST_DRAIN: begin
                    if (layer == LAST_LAYER) begin
                        layer <= '0;
                        state <= ST_UNLOAD;
                    end else begin
                        layer <= layer + 1'b1;
                        state <= ST_COMPUTE;
                    end
                end

                ST_UNLOAD: begin
                    idx <= idx + 1'b1;
                    if (idx == LAST_IDX) begin
                        state <= ST_LOAD;
                    end
                end

                default: begin
                    state <= ST_LOAD;
                end
            endcase
        end
    end

endmodule

// File: logic/twiddle_rom.sv
`timescale 1ns/1ps

module twiddle_rom import ntt_pkg::*; #(
    parameter int NUM_BFU = 8
) (
    input  bfu_cmd_t            i_cmd,
    output coef_t [NUM_BFU-1:0] o_zeta
);

    coef_t      zeta_tab [128];
    logic [6:0] bfly     [NUM_BFU];
    logic [6:0] zeta_idx [NUM_BFU];

    // constant table, folded at elaboration
    for (genvar g = 0; g < 128; g++) begin : g_tab
        assign zeta_tab[g] = zeta_of(7'(g));
    end

    // layer l uses zetas 2^l up to 2^(l+1)-1, one per block
    always_comb begin
        for (int i = 0; i < NUM_BFU; i++) begin
            bfly[i]     = i_cmd.group_base + 7'(i);
            zeta_idx[i] = (7'd1 << i_cmd.layer) + (bfly[i] >> (3'd7 - i_cmd.layer));
            o_zeta[i]   = zeta_tab[zeta_idx[i]];
        end
    end

endmodule

// File: common/ntt_pkg.sv
package ntt_pkg;

    // kyber ring parameters
    localparam int Q      = 3329;
    localparam int N      = 256;
    localparam int LAYERS = 7;
    localparam int COEF_W = 12;
    localparam int IDX_W  = 8;

    typedef logic [COEF_W-1:0] coef_t;

    // one issued group of butterflies
    typedef struct packed {
        logic       valid;
        logic [2:0] layer;
        logic [6:0] group_base;
    } bfu_cmd_t;

    typedef enum logic [1:0] {
        ST_LOAD,
        ST_COMPUTE,
        ST_DRAIN,
        ST_UNLOAD
    } ctrl_state_t;

    // 17 to the power bitrev7(idx), mod q
    function automatic coef_t zeta_of(input logic [6:0] idx);
        logic [6:0]  rev;
        int unsigned acc;
        for (int b = 0; b < 7; b++) begin
            rev[b] = idx[6-b];
        end
        acc = 1;
        // fixed trip count keeps the loop constant for elaboration
        for (int e = 0; e < 128; e++) begin
            if (e < int'(rev)) begin
                acc = (acc * 17) % Q;
            end
        end
        return coef_t'(acc);
    endfunction

    // lower index of butterfly k in a layer
    // upper index is this plus 128 >> layer
    function automatic logic [IDX_W-1:0] pair_lo_index(
        input logic [2:0] layer,
        input logic [6:0] k
    );
        logic [IDX_W-1:0] half;
        logic [IDX_W-1:0] low_mask;
        logic [IDX_W-1:0] kk;
        half     = IDX_W'(128) >> layer;
        low_mask = half - 1'b1;
        kk       = {1'b0, k};
        // block number moves up one bit, offset stays
        return ((kk & ~low_mask) << 1) | (kk & low_mask);
    endfunction

endpackage
